// ==== source/riscvSettings.svh ====
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

`define RISCV_XLEN 32
`define RISCV_REG_COUNT 32
`define RISCV_RESET_PC 32'h0000_0000

`endif

// ==== source/riscvInstrPkg.sv ====
`include "riscvSettings.svh"
`default_nettype none

package riscvInstrPkg;

    typedef logic [`RISCV_XLEN-1:0] riscvWord;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode      op;
    } rType;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode       op;
    } iType;

    typedef struct packed {
        logic [6:0] immHigh;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLow;
        opcode      op;
    } sType;

    typedef struct packed {
        logic       immSign;
        logic [5:0] immHigh;   // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLow;    // imm[4:1]
        logic       imm11;
        opcode      op;
    } bType;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode       op;
    } uType;

    typedef struct packed {
        logic       immSign;
        logic [9:0] immLow;    // imm[10:1]
        logic       imm11;
        logic [7:0] immHigh;   // imm[19:12]
        logic [4:0] rd;
        opcode      op;
    } jType;

    typedef union packed {
        rType r;
        iType i;
        sType s;
        bType b;
        uType u;
        jType j;
    } instruction;

endpackage

`default_nettype wire

// ==== source/riscvControlPkg.sv ====
`default_nettype none

package riscvControlPkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } aluOperation;

    typedef enum logic [2:0] {
        CLASS_MEM,          // Address add for loads, stores, jumps
        CLASS_BRANCH,
        CLASS_REGISTER,
        CLASS_IMMEDIATE,
        CLASS_UPPER
    } aluOpClass;

    typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_JUMP} pcSource;

    typedef enum logic [1:0] {FWD_REGFILE, FWD_MEM, FWD_WB} forwardSelect;

    typedef enum logic [1:0] {OPA_REGISTER, OPA_PC, OPA_ZERO} operandASource;

endpackage

`default_nettype wire

// ==== source/mainDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
    input  riscvInstrPkg::opcode              instructionOpcode,
    output logic                              branch,
    output logic                              memRead,
    output logic                              memToReg,
    output logic                              memWrite,
    output logic                              aluSource,
    output logic                              regWrite,
    output logic                              jump,
    output riscvControlPkg::aluOpClass        aluOpClass,
    output riscvControlPkg::operandASource    operandSelect
);
    import riscvInstrPkg::*;
    import riscvControlPkg::*;

    always_comb begin
        branch        = 1'b0;
        memRead       = 1'b0;
        memToReg      = 1'b0;
        memWrite      = 1'b0;
        aluSource     = 1'b0;
        regWrite      = 1'b0;
        jump          = 1'b0;
        aluOpClass    = CLASS_MEM;
        operandSelect = OPA_REGISTER;
        case (instructionOpcode)
            OP: begin
                regWrite   = 1'b1;
                aluOpClass = CLASS_REGISTER;
            end
            OP_IMM: begin
                regWrite   = 1'b1;
                aluSource  = 1'b1;
                aluOpClass = CLASS_IMMEDIATE;
            end
            LOAD: begin
                memRead   = 1'b1;
                memToReg  = 1'b1;
                aluSource = 1'b1;
                regWrite  = 1'b1;
            end
            STORE: begin
                memWrite  = 1'b1;
                aluSource = 1'b1;
            end
            BRANCH: begin
                branch     = 1'b1;
                aluOpClass = CLASS_BRANCH;
            end
            JAL, JALR: begin
                jump      = 1'b1;
                regWrite  = 1'b1;
                aluSource = 1'b1;   // ALU forms the target
                if (instructionOpcode == JAL)
                    operandSelect = OPA_PC;
            end
            LUI, AUIPC: begin
                regWrite      = 1'b1;
                aluSource     = 1'b1;
                aluOpClass    = CLASS_UPPER;
                operandSelect = (instructionOpcode == LUI) ? OPA_ZERO : OPA_PC;
            end
            default: ;          // Bubble
        endcase
    end

endmodule

`default_nettype wire

// ==== source/aluDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
    input  riscvControlPkg::aluOpClass    opClass,
    input  logic [2:0]                    funct3,
    input  logic                          funct7Bit,
    output riscvControlPkg::aluOperation  operation
);
    import riscvControlPkg::*;

    always_comb begin
        operation = ALU_ADD;
        case (opClass)
            CLASS_BRANCH: begin
                case (funct3[2:1])
                    2'b10:   operation = ALU_SLT;     // BLT, BGE
                    2'b11:   operation = ALU_SLTU;    // BLTU, BGEU
                    default: operation = ALU_SUB;     // BEQ, BNE
                endcase
            end
            CLASS_REGISTER, CLASS_IMMEDIATE: begin
                case (funct3)
                    3'b000: begin
                        if (funct7Bit && opClass == CLASS_REGISTER)
                            operation = ALU_SUB;
                        else
                            operation = ALU_ADD;
                    end
                    3'b001:  operation = ALU_SLL;
                    3'b010:  operation = ALU_SLT;
                    3'b011:  operation = ALU_SLTU;
                    3'b100:  operation = ALU_XOR;
                    3'b101:  operation = funct7Bit ? ALU_SRA : ALU_SRL;
                    3'b110:  operation = ALU_OR;
                    default: operation = ALU_AND;
                endcase
            end
            default: operation = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/forwardingUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module forwardingUnit (
    input  logic [4:0]                      sourceA,
    input  logic [4:0]                      sourceB,
    input  logic [4:0]                      destinationMem,
    input  logic [4:0]                      destinationWb,
    input  logic                            regWriteMem,
    input  logic                            regWriteWb,
    output riscvControlPkg::forwardSelect   forwardA,
    output riscvControlPkg::forwardSelect   forwardB
);
    import riscvControlPkg::*;

    logic memValid, wbValid;

    assign memValid = regWriteMem && destinationMem != 5'd0;
    assign wbValid  = regWriteWb && destinationWb != 5'd0;

    // Younger result in MEM wins
    always_comb begin
        forwardA = FWD_REGFILE;
        forwardB = FWD_REGFILE;
        if (memValid && destinationMem == sourceA)
            forwardA = FWD_MEM;
        else if (wbValid && destinationWb == sourceA)
            forwardA = FWD_WB;
        if (memValid && destinationMem == sourceB)
            forwardB = FWD_MEM;
        else if (wbValid && destinationWb == sourceB)
            forwardB = FWD_WB;
    end

endmodule

`default_nettype wire

// ==== source/controlPath.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlPath (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              zero,
    input  riscvInstrPkg::instruction         instructionId,
    output logic                              memRead,
    output logic                              memToReg,
    output logic                              memWrite,
    output logic                              aluSource,
    output logic                              regWrite,
    output logic                              jump,
    output riscvControlPkg::aluOperation      aluOperation,
    output riscvControlPkg::pcSource          pcSelect,
    output riscvControlPkg::operandASource    operandSelect,
    output riscvControlPkg::forwardSelect     forwardA,
    output riscvControlPkg::forwardSelect     forwardB
);
    import riscvInstrPkg::*;
    import riscvControlPkg::*;

    instruction instructionEx, instructionMem, instructionWb;
    logic branchId, memReadId, memToRegId, memWriteId, aluSourceId, regWriteId, jumpId;
    logic branchEx, memReadEx, memToRegEx, memWriteEx, regWriteEx, jumpEx;
    logic branchMem, memToRegMem, regWriteMem, jumpMem, zeroMem;
    aluOpClass opClassId, opClassEx;
    operandASource operandSelectId;

    mainDecoder decoder (
        .instructionOpcode(instructionId.r.op),
        .branch(branchId),
        .memRead(memReadId),
        .memToReg(memToRegId),
        .memWrite(memWriteId),
        .aluSource(aluSourceId),
        .regWrite(regWriteId),
        .jump(jumpId),
        .aluOpClass(opClassId),
        .operandSelect(operandSelectId)
    );

    aluDecoder aluControl (
        .opClass(opClassEx),
        .funct3(instructionEx.r.funct3),
        .funct7Bit(instructionEx.r.funct7[5]),
        .operation(aluOperation)
    );

    forwardingUnit forwarding (
        .sourceA(instructionEx.r.rs1),
        .sourceB(instructionEx.r.rs2),
        .destinationMem(instructionMem.r.rd),
        .destinationWb(instructionWb.r.rd),
        .regWriteMem(regWriteMem),
        .regWriteWb(regWrite),
        .forwardA(forwardA),
        .forwardB(forwardB)
    );

    // Zero flag meaning depends on which compare the ALU ran
    always_comb begin
        pcSelect = PC_NEXT;
        if (branchMem) begin
            case (instructionMem.b.funct3)
                3'b000, 3'b101, 3'b111: pcSelect = zeroMem ? PC_BRANCH : PC_NEXT;
                3'b001, 3'b100, 3'b110: pcSelect = zeroMem ? PC_NEXT : PC_BRANCH;
                default:                pcSelect = PC_NEXT;
            endcase
        end else if (jumpMem) begin
            pcSelect = PC_JUMP;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            {branchEx, memReadEx, memToRegEx, memWriteEx, regWriteEx, jumpEx} <= '0;
            aluSource     <= 1'b0;
            opClassEx     <= CLASS_MEM;
            operandSelect <= OPA_REGISTER;
            {branchMem, memRead, memToRegMem, memWrite, regWriteMem, jumpMem} <= '0;
            {memToReg, regWrite, jump} <= '0;
        end else begin
            branchEx      <= branchId;      // ID/EX
            memReadEx     <= memReadId;
            memToRegEx    <= memToRegId;
            memWriteEx    <= memWriteId;
            regWriteEx    <= regWriteId;
            jumpEx        <= jumpId;
            aluSource     <= aluSourceId;
            opClassEx     <= opClassId;
            operandSelect <= operandSelectId;
            branchMem     <= branchEx;      // EX/MEM
            memRead       <= memReadEx;
            memToRegMem   <= memToRegEx;
            memWrite      <= memWriteEx;
            regWriteMem   <= regWriteEx;
            jumpMem       <= jumpEx;
            memToReg      <= memToRegMem;   // MEM/WB
            regWrite      <= regWriteMem;
            jump          <= jumpMem;
        end
    end

    always_ff @(posedge clock) begin
        instructionEx  <= instructionId;
        instructionMem <= instructionEx;
        instructionWb  <= instructionMem;
        zeroMem        <= zero;
    end

    // One instruction is never both a branch and a jump
    assert property (@(posedge clock) disable iff (reset) !(branchMem && jumpMem));

endmodule

`default_nettype wire

// ==== source/dataPath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscvSettings.svh"

module dataPath (
    input  logic                              clock,
    input  logic                              reset,
    input  riscvInstrPkg::instruction         instruction,
    input  riscvInstrPkg::riscvWord           dataReadValue,
    input  logic                              memRead,
    input  logic                              memToReg,
    input  logic                              memWrite,
    input  logic                              aluSource,
    input  logic                              regWrite,
    input  logic                              jump,
    input  riscvControlPkg::aluOperation      aluOperation,
    input  riscvControlPkg::pcSource          pcSelect,
    input  riscvControlPkg::operandASource    operandSelect,
    input  riscvControlPkg::forwardSelect     forwardA,
    input  riscvControlPkg::forwardSelect     forwardB,
    output riscvInstrPkg::riscvWord           instructionAddress,
    output riscvInstrPkg::riscvWord           dataAddress,
    output riscvInstrPkg::riscvWord           dataWriteValue,
    output riscvInstrPkg::instruction         instructionId,
    output logic                              zero
);
    import riscvInstrPkg::*;
    import riscvControlPkg::*;

    localparam int shiftWidth = $clog2(`RISCV_XLEN);

    riscvWord registers [`RISCV_REG_COUNT];
    riscvWord pc, pcId, pcEx, readA, readB, immediateId, immediateEx, valueAEx, valueBEx;
    riscvWord forwardedA, forwardedB, operandA, operandB, aluResult;
    riscvWord aluResultMem, storeValueMem, branchTargetMem, jumpTargetMem, linkMem, resultMem;
    riscvWord aluResultWb, loadValueWb, linkWb, writeValue;
    logic [4:0] rdEx, rdMem, rdWb;

    function automatic riscvWord pickOperand(forwardSelect select, riscvWord fileValue,
                                             riscvWord memValue, riscvWord wbValue);
        case (select)
            FWD_MEM: return memValue;
            FWD_WB:  return wbValue;
            default: return fileValue;
        endcase
    endfunction

    always_ff @(posedge clock) begin
        if (reset)
            pc <= `RISCV_RESET_PC;
        else if (pcSelect == PC_BRANCH)
            pc <= branchTargetMem;
        else if (pcSelect == PC_JUMP)
            pc <= jumpTargetMem;
        else
            pc <= pc + 4;
    end

    assign instructionAddress = pc;

    always_ff @(posedge clock) begin
        if (reset)
            instructionId <= '0;    // Opcode 0 decodes as a bubble
        else
            instructionId <= instruction;
        pcId <= pc;
    end

    // Same-cycle write is visible to the read
    assign readA = (instructionId.r.rs1 == 5'd0) ? '0 :
                   (regWrite && rdWb == instructionId.r.rs1) ? writeValue :
                   registers[instructionId.r.rs1];
    assign readB = (instructionId.r.rs2 == 5'd0) ? '0 :
                   (regWrite && rdWb == instructionId.r.rs2) ? writeValue :
                   registers[instructionId.r.rs2];

    always_ff @(posedge clock) begin
        if (regWrite && rdWb != 5'd0)
            registers[rdWb] <= writeValue;
    end

    always_comb begin
        case (instructionId.r.op)
            LUI, AUIPC: immediateId = riscvWord'($signed({instructionId.u.imm, 12'b0}));
            STORE:      immediateId = riscvWord'($signed({instructionId.s.immHigh,
                                                          instructionId.s.immLow}));
            BRANCH:     immediateId = riscvWord'($signed({instructionId.b.immSign,
                                                          instructionId.b.imm11,
                                                          instructionId.b.immHigh,
                                                          instructionId.b.immLow, 1'b0}));
            JAL:        immediateId = riscvWord'($signed({instructionId.j.immSign,
                                                          instructionId.j.immHigh,
                                                          instructionId.j.imm11,
                                                          instructionId.j.immLow, 1'b0}));
            default:    immediateId = riscvWord'($signed(instructionId.i.imm));
        endcase
    end

    always_ff @(posedge clock) begin
        pcEx        <= pcId;
        valueAEx    <= readA;
        valueBEx    <= readB;
        immediateEx <= immediateId;
        rdEx        <= instructionId.r.rd;
    end

    assign forwardedA = pickOperand(forwardA, valueAEx, resultMem, writeValue);
    assign forwardedB = pickOperand(forwardB, valueBEx, resultMem, writeValue);
    assign operandA = (operandSelect == OPA_PC) ? pcEx :
                      (operandSelect == OPA_ZERO) ? '0 : forwardedA;
    assign operandB = aluSource ? immediateEx : forwardedB;

    always_comb begin
        case (aluOperation)
            ALU_SUB:  aluResult = operandA - operandB;
            ALU_AND:  aluResult = operandA & operandB;
            ALU_OR:   aluResult = operandA | operandB;
            ALU_XOR:  aluResult = operandA ^ operandB;
            ALU_SLL:  aluResult = operandA << operandB[shiftWidth-1:0];
            ALU_SRL:  aluResult = operandA >> operandB[shiftWidth-1:0];
            ALU_SRA:  aluResult = $signed(operandA) >>> operandB[shiftWidth-1:0];
            ALU_SLT:  aluResult = riscvWord'($signed(operandA) < $signed(operandB));
            ALU_SLTU: aluResult = riscvWord'(operandA < operandB);
            default:  aluResult = operandA + operandB;
        endcase
    end

    assign zero = (aluResult == '0);

    always_ff @(posedge clock) begin
        aluResultMem    <= aluResult;
        storeValueMem   <= forwardedB;
        branchTargetMem <= pcEx + immediateEx;
        jumpTargetMem   <= {aluResult[`RISCV_XLEN-1:1], 1'b0};
        linkMem         <= pcEx + 4;
        rdMem           <= rdEx;
    end

    assign dataAddress    = aluResultMem;
    assign dataWriteValue = storeValueMem;
    // A jump in MEM forwards its link address, not its target
    assign resultMem = (pcSelect == PC_JUMP) ? linkMem : aluResultMem;

    always_ff @(posedge clock) begin
        aluResultWb <= aluResultMem;
        loadValueWb <= dataReadValue;
        linkWb      <= linkMem;
        rdWb        <= rdMem;
    end

    assign writeValue = memToReg ? loadValueWb : (jump ? linkWb : aluResultWb);

    assert property (@(posedge clock) disable iff (reset) !(memRead && memWrite));

endmodule

`default_nettype wire

// ==== source/riscvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvCore (
    input  logic                        clock,
    input  logic                        reset,
    input  riscvInstrPkg::instruction   instruction,
    input  riscvInstrPkg::riscvWord     dataReadValue,
    output riscvInstrPkg::riscvWord     instructionAddress,
    output riscvInstrPkg::riscvWord     dataAddress,
    output riscvInstrPkg::riscvWord     dataWriteValue,
    output logic                        dataWrite,
    output logic                        dataRead
);
    import riscvControlPkg::*;

    riscvInstrPkg::instruction instructionId;   // Type name shadowed by the port
    logic zero, memToReg, aluSource, regWrite, jump;
    aluOperation operationEx;
    pcSource pcSelect;
    operandASource operandSelect;
    forwardSelect forwardA, forwardB;

    controlPath controlUnit (
        .clock(clock),
        .reset(reset),
        .zero(zero),
        .instructionId(instructionId),
        .memRead(dataRead),
        .memToReg(memToReg),
        .memWrite(dataWrite),
        .aluSource(aluSource),
        .regWrite(regWrite),
        .jump(jump),
        .aluOperation(operationEx),
        .pcSelect(pcSelect),
        .operandSelect(operandSelect),
        .forwardA(forwardA),
        .forwardB(forwardB)
    );

    dataPath dataUnit (
        .clock(clock),
        .reset(reset),
        .instruction(instruction),
        .dataReadValue(dataReadValue),
        .memRead(dataRead),
        .memToReg(memToReg),
        .memWrite(dataWrite),
        .aluSource(aluSource),
        .regWrite(regWrite),
        .jump(jump),
        .aluOperation(operationEx),
        .pcSelect(pcSelect),
        .operandSelect(operandSelect),
        .forwardA(forwardA),
        .forwardB(forwardB),
        .instructionAddress(instructionAddress),
        .dataAddress(dataAddress),
        .dataWriteValue(dataWriteValue),
        .instructionId(instructionId),
        .zero(zero)
    );

endmodule

`default_nettype wire

// ==== testbench/riscvCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscvSettings.svh"

module riscvCoreTb;
    import riscvInstrPkg::*;

    localparam riscvWord nopWord = 32'h0000_0013;   // ADDI x0, x0, 0
    localparam int idleLimit = 2000;

    logic clock = 1'b0;
    logic reset;
    instruction instructionBus;
    riscvWord dataReadValue, instructionAddress, dataAddress, dataWriteValue;
    logic dataWrite, dataRead;

    riscvWord imem [1024];
    riscvWord dmem [256];
    riscvWord modelMem [256];
    riscvWord regs [32];
    opcode progOp [1024];
    int progF3 [1024], progAlt [1024], progRd [1024], progRs1 [1024], progRs2 [1024];
    riscvWord progImm [1024];
    int progLen, loopIndex, errors;
    int seed = 32'h55b67ca4;
    riscvWord fetchQ [$];
    riscvWord storeAddrQ [$];
    riscvWord storeValQ [$];
    riscvWord loadAddrQ [$];

    riscvCore DUT (
        .clock(clock),
        .reset(reset),
        .instruction(instructionBus),
        .dataReadValue(dataReadValue),
        .instructionAddress(instructionAddress),
        .dataAddress(dataAddress),
        .dataWriteValue(dataWriteValue),
        .dataWrite(dataWrite),
        .dataRead(dataRead)
    );

    always #2 clock = ~clock;

    // Both memories answer in the same cycle
    assign instructionBus = imem[instructionAddress[11:2]];
    assign dataReadValue  = dmem[dataAddress[9:2]];

    always @(posedge clock) begin
        if (dataWrite)
            dmem[dataAddress[9:2]] <= dataWriteValue;
    end

    function automatic riscvWord fillWord(int index);
        riscvWord i;
        i = index;
        return (i * 32'h9e37_79b1) ^ {i[7:0], 24'h5a_c3e1};
    endfunction

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic riscvWord randImm12();
        logic [11:0] v;
        v = $random(seed);
        return {{20{v[11]}}, v};
    endfunction

    function automatic riscvWord refAlu(int f3, int alt, riscvWord a, riscvWord b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: return (a < b) ? 32'd1 : 32'd0;
            4: return a ^ b;
            5: return alt ? riscvWord'($signed(a) >>> b[4:0]) : a >> b[4:0];
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(int f3, riscvWord a, riscvWord b);
        case (f3)
            0: return a == b;
            1: return a != b;
            4: return $signed(a) < $signed(b);
            5: return $signed(a) >= $signed(b);
            6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic failRun(string message);
        errors++;
        $display("%s", message);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic compareFetch(string name, riscvWord expected, riscvWord actual);
        if (actual !== expected)
            failRun($sformatf("MISMATCH %s fetch: expected %h actual %h", name, expected, actual));
    endtask

    task automatic compareLoad(string name, riscvWord expected, riscvWord actual);
        if (actual !== expected)
            failRun($sformatf("MISMATCH %s load: expected %h actual %h", name, expected, actual));
    endtask

    task automatic compareStore(string name, riscvWord expAddr, riscvWord actAddr,
                                riscvWord expValue, riscvWord actValue);
        if (actAddr !== expAddr || actValue !== expValue)
            failRun($sformatf("MISMATCH %s store: expected %h=%h actual %h=%h",
                              name, expAddr, expValue, actAddr, actValue));
    endtask

    task automatic emit(opcode op, int f3, int alt, int rd, int rs1, int rs2, riscvWord imm);
        logic [4:0] d, s1, s2;
        logic [2:0] f;
        riscvWord w;
        d  = rd[4:0];
        s1 = rs1[4:0];
        s2 = rs2[4:0];
        f  = f3[2:0];
        case (op)
            OP:     w = {1'b0, alt[0], 5'b0, s2, s1, f, d, op};
            OP_IMM: w = (f == 3'd1 || f == 3'd5) ? {1'b0, alt[0], 5'b0, imm[4:0], s1, f, d, op}
                                                 : {imm[11:0], s1, f, d, op};
            LOAD:   w = {imm[11:0], s1, 3'b010, d, op};
            JALR:   w = {imm[11:0], s1, 3'b000, d, op};
            STORE:  w = {imm[11:5], s2, s1, 3'b010, imm[4:0], op};
            BRANCH: w = {imm[12], imm[10:5], s2, s1, f, imm[4:1], imm[11], op};
            JAL:    w = {imm[20], imm[10:1], imm[11], imm[19:12], d, op};
            default: w = {imm[19:0], d, op};     // LUI, AUIPC
        endcase
        imem[progLen]    = w;
        progOp[progLen]  = op;
        progF3[progLen]  = f3;
        progAlt[progLen] = alt;
        progRd[progLen]  = rd;
        progRs1[progLen] = rs1;
        progRs2[progLen] = rs2;
        progImm[progLen] = imm;
        progLen++;
    endtask

    // Small pools give dense dependencies at every distance
    task automatic genAlu(int pool);
        int f3;
        f3 = rnd(8);
        if (rnd(2) == 0)
            emit(OP, f3, (f3 == 0 || f3 == 5) ? rnd(2) : 0, rnd(pool), rnd(pool), rnd(pool), 0);
        else if (f3 == 1 || f3 == 5)
            emit(OP_IMM, f3, (f3 == 5) ? rnd(2) : 0, rnd(pool), rnd(pool), 0, rnd(32));
        else
            emit(OP_IMM, f3, 0, rnd(pool), rnd(pool), 0, randImm12());
    endtask

    task automatic buildProgram(int mode);
        int skip, rt, off, a, b, target;
        int branchF3 [6] = '{0, 1, 4, 5, 6, 7};
        progLen = 0;
        foreach (imem[i])
            imem[i] = nopWord;
        for (int r = 1; r < 32; r++) begin
            emit(LUI, 0, 0, r, 0, 0, rnd(1 << 20));
            emit(OP_IMM, 0, 0, r, r, 0, randImm12());
        end
        for (int blk = 0; blk < 40; blk++) begin
            skip = rnd(4);
            case (mode)
                0: genAlu(32);
                1: genAlu(4);
                2: case (rnd(5))
                    0: emit(STORE, 2, 0, 0, 0, rnd(32), 4 * rnd(64));
                    1: begin
                        emit(LOAD, 2, 0, rnd(32), 0, 0, 4 * rnd(64));
                        emit(OP_IMM, 0, 0, 0, 0, 0, 0);   // Load-use gap
                    end
                    2: emit(LUI, 0, 0, rnd(32), 0, 0, rnd(1 << 20));
                    3: emit(AUIPC, 0, 0, rnd(32), 0, 0, rnd(1 << 20));
                    default: genAlu(32);
                endcase
                3: begin
                    a = rnd(32);
                    b = rnd(32);
                    case (rnd(4))
                        0: emit(OP_IMM, 0, 0, b, a, 0, 0);            // Equal operands
                        1: emit(LUI, 0, 0, a, 0, 0, 32'h80000);       // Most negative
                        2: emit(OP_IMM, 0, 0, b, 0, 0, 32'hffff_ffff);
                        default: genAlu(32);
                    endcase
                    emit(BRANCH, branchF3[rnd(6)], 0, 0, a, b, 4 * (4 + skip));
                    repeat (3 + skip) genAlu(32);
                end
                default: begin
                    if (rnd(2) == 0) begin
                        emit(JAL, 0, 0, rnd(32), 0, 0, 4 * (4 + skip));
                    end else begin
                        rt = 1 + rnd(31);
                        off = rnd(16);
                        target = 4 * (progLen + 1 + 4 + skip);
                        emit(OP_IMM, 0, 0, rt, 0, 0, target - off + rnd(2));
                        emit(JALR, 0, 0, rnd(32), rt, 0, off);
                    end
                    repeat (3 + skip) genAlu(32);
                end
            endcase
        end
        for (int r = 1; r < 32; r++)
            emit(STORE, 2, 0, 0, 0, r, 512 + 4 * r);
        loopIndex = progLen;
        emit(JAL, 0, 0, 0, 0, 0, 0);
    endtask

    // Redirect lands after three more instructions retire
    task automatic runModel();
        riscvWord pc, a, b, result, addr, target, nextPc;
        int idx, countdown, steps;
        logic write, taken;
        fetchQ.delete();
        storeAddrQ.delete();
        storeValQ.delete();
        loadAddrQ.delete();
        foreach (regs[i])
            regs[i] = '0;
        foreach (modelMem[i])
            modelMem[i] = fillWord(i);
        pc = `RISCV_RESET_PC;
        countdown = 0;
        steps = 0;
        target = '0;
        while (pc[11:2] != loopIndex && steps < 4000) begin
            idx = pc[11:2];
            fetchQ.push_back(pc);
            a = regs[progRs1[idx]];
            b = regs[progRs2[idx]];
            addr = a + progImm[idx];
            result = '0;
            write = 1'b1;
            taken = 1'b0;
            case (progOp[idx])
                OP:     result = refAlu(progF3[idx], progAlt[idx], a, b);
                OP_IMM: result = refAlu(progF3[idx], progAlt[idx], a, progImm[idx]);
                LUI:    result = {progImm[idx][19:0], 12'b0};
                AUIPC:  result = pc + {progImm[idx][19:0], 12'b0};
                LOAD: begin
                    result = modelMem[addr[9:2]];
                    loadAddrQ.push_back(addr);
                end
                STORE: begin
                    write = 1'b0;
                    modelMem[addr[9:2]] = b;
                    storeAddrQ.push_back(addr);
                    storeValQ.push_back(b);
                end
                BRANCH: begin
                    write = 1'b0;
                    taken = branchTaken(progF3[idx], a, b);
                end
                default: begin
                    result = pc + 4;
                    taken = 1'b1;
                end
            endcase
            if (write && progRd[idx] != 0)
                regs[progRd[idx]] = result;
            nextPc = pc + 4;
            if (countdown > 0) begin
                countdown--;
                if (countdown == 0)
                    nextPc = target;
            end
            if (taken) begin
                countdown = 3;
                target = (progOp[idx] == JALR) ? {addr[31:1], 1'b0} : pc + progImm[idx];
            end
            pc = nextPc;
            steps++;
        end
        if (steps >= 4000)
            failRun("reference model never reached the final loop");
        fetchQ.push_back(pc);
    endtask

    task automatic applyReset();
        @(posedge clock);
        reset <= 1'b1;
        foreach (dmem[i])
            dmem[i] = fillWord(i);
        for (int i = 0; i < 16; i++) begin
            @(negedge clock);
            if (i >= 2) begin
                if (dataWrite !== 1'b0 || dataRead !== 1'b0)
                    failRun("memory strobe was active while reset was held");
                compareFetch("reset", `RISCV_RESET_PC, instructionAddress);
            end
            @(posedge clock);
        end
        reset <= 1'b0;
    endtask

    task automatic runProgram(string name, int mode);
        int fi, si, li, idle;
        buildProgram(mode);
        runModel();
        applyReset();
        fi = 0;
        si = 0;
        li = 0;
        idle = 0;
        while (fi < fetchQ.size() || si < storeAddrQ.size() || li < loadAddrQ.size()) begin
            @(negedge clock);
            if (fi < fetchQ.size()) begin
                compareFetch(name, fetchQ[fi], instructionAddress);
                fi++;
            end
            if (dataRead) begin
                if (li >= loadAddrQ.size())
                    failRun("core issued a load the program never made");
                compareLoad(name, loadAddrQ[li], dataAddress);
                li++;
            end
            if (dataWrite) begin
                if (si >= storeAddrQ.size())
                    failRun("core issued a store the program never made");
                compareStore(name, storeAddrQ[si], dataAddress, storeValQ[si], dataWriteValue);
                si++;
                idle = 0;
            end else begin
                idle++;
                if (idle > idleLimit)
                    failRun("core stopped storing before the register dump finished");
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        errors = 0;
        progLen = 0;
        foreach (imem[i])
            imem[i] = nopWord;
        runProgram("arith", 0);
        runProgram("forwarding", 1);
        runProgram("memory", 2);
        runProgram("branch", 3);
        runProgram("jump", 4);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== riscvCore.f ====
+incdir+source
source/riscvInstrPkg.sv
source/riscvControlPkg.sv
source/mainDecoder.sv
source/aluDecoder.sv
source/forwardingUnit.sv
source/controlPath.sv
source/dataPath.sv
source/riscvCore.sv
testbench/riscvCoreTb.sv
